// File: filelist.f
common/serial_link_pkg.sv
network/serial_link_recv_fifo.sv
network/serial_link_network.sv
data_link/serial_link_data_link.sv
physical/serial_link_physical.sv
hw/serial_link.sv
sim/tb_serial_link.sv

// File: sim/tb_serial_link.sv
//////////////////////////////
// Loopback testbench for the serial link
// Lanes and forwarded clock go straight back into the receiver
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_serial_link import serial_link_pkg::*; ();

  localparam int DataWidth       = DefaultDataWidth;
  localparam int NumLanes        = DefaultNumLanes;
  localparam int NumCredits      = DefaultNumCredits;
  localparam int ClkDiv          = DefaultClkDiv;
  // Payload holds the word, the tag bit and the credit field
  localparam int PayloadBits     = DataWidth + 1 + $clog2(NumCredits) + 1;
  localparam int FlitsPerPayload = (PayloadBits + NumLanes - 1) / NumLanes;
  localparam int StallCycles     = 4 * ClkDiv * FlitsPerPayload;
  localparam int SendTimeout     = 400;
  localparam int DrainTimeout    = 4000;

  logic                 clk;
  logic                 rst_n;
  logic [DataWidth-1:0] tx_data;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [DataWidth-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_ready;
  logic [NumLanes-1:0]  lanes;
  logic                 fwd_clk;

  logic [DataWidth-1:0] expected_q [$];
  string                test_name;

  serial_link #(
    .DataWidth  ( DataWidth  ),
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits ),
    .ClkDiv     ( ClkDiv     )
  ) dut (
    .clk_i         ( clk      ),
    .rst_n_i       ( rst_n    ),
    .tx_data_i     ( tx_data  ),
    .tx_valid_i    ( tx_valid ),
    .tx_ready_o    ( tx_ready ),
    .rx_data_o     ( rx_data  ),
    .rx_valid_o    ( rx_valid ),
    .rx_ready_i    ( rx_ready ),
    .ddr_i         ( lanes    ),
    .ddr_o         ( lanes    ),
    .ddr_rcv_clk_i ( fwd_clk  ),
    .ddr_rcv_clk_o ( fwd_clk  )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      report_error($sformatf("CHECK FAILED %s: %s expected %0h, actual %0h",
                             test_name, what, expected, actual));
    end
  endtask

  // Inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // Offers one word and gives up after max_cycles without a handshake
  task automatic try_send(input logic [DataWidth-1:0] word, input int max_cycles,
                          output logic accepted);
    int   cycles;
    logic ready_seen;
    cycles   = 0;
    accepted = 1'b0;
    tx_data  = word;
    tx_valid = 1'b1;
    while (!accepted && cycles < max_cycles) begin
      @(negedge clk);
      ready_seen = tx_ready;
      next_cycle();
      accepted = ready_seen;
      cycles++;
    end
    tx_valid = 1'b0;
    if (accepted) begin
      expected_q.push_back(word);
    end
  endtask

  task automatic send_word(input logic [DataWidth-1:0] word);
    logic accepted;
    try_send(word, SendTimeout, accepted);
    assert (accepted) else begin
      report_error($sformatf("%s: tx_ready_o did not rise within %0d cycles",
                             test_name, SendTimeout));
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < DrainTimeout) begin
      next_cycle();
      cycles++;
    end
    assert (expected_q.size() == 0) else begin
      report_error($sformatf("%s: %0d words never came out on the receive stream",
                             test_name, expected_q.size()));
    end
  endtask

  task automatic check_idle_outputs();
    check_equal("rx_valid_o", 1'b0, rx_valid);
    check_equal("ddr_rcv_clk_o", 1'b0, fwd_clk);
    check_equal("ddr_o", '0, lanes);
  endtask

  // Scoreboard samples the receive handshake half a cycle before the edge
  always @(negedge clk) begin
    if (rst_n && rx_valid && rx_ready) begin
      assert (expected_q.size() != 0) else begin
        report_error($sformatf("%s: word %0h came out with none expected",
                               test_name, rx_data));
      end
      check_equal("received word", expected_q.pop_front(), rx_data);
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    repeat (16) begin
      next_cycle();
      check_idle_outputs();
    end
    rst_n = 1'b1;
    check_idle_outputs();
    next_cycle();
    check_equal("tx_ready_o", 1'b1, tx_ready);
  endtask

  task automatic test_single_word();
    test_name = "single_word";
    rx_ready  = 1'b1;
    send_word(16'ha5c3);
    wait_drain();
  endtask

  task automatic test_ordered_stream();
    test_name = "ordered_stream";
    rx_ready  = 1'b1;
    repeat (20) begin
      send_word(DataWidth'($urandom()));
    end
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic accepted;
    int   accepted_count;
    int   attempts;
    test_name      = "back_pressure";
    rx_ready       = 1'b0;
    accepted       = 1'b1;
    accepted_count = 0;
    attempts       = 0;
    // Stop once tx_ready_o stays low for a long stretch
    while (accepted && attempts < NumCredits + 4) begin
      try_send(DataWidth'($urandom()), StallCycles, accepted);
      if (accepted) begin
        accepted_count++;
      end
      attempts++;
    end
    check_equal("accepted words", NumCredits, accepted_count);
    rx_ready = 1'b1;
    wait_drain();
  endtask

  task automatic test_credit_return();
    test_name = "credit_return";
    rx_ready  = 1'b1;
    repeat (NumCredits + 4) begin
      send_word(DataWidth'($urandom()));
    end
    wait_drain();
  endtask

  initial begin
    int seed_value;
    seed_value  = $urandom(32'hb646_6a4a);
    test_name   = "init";
    rst_n       = 1'b0;
    tx_data     = '0;
    tx_valid    = 1'b0;
    rx_ready    = 1'b0;

    test_reset();
    test_single_word();
    test_ordered_stream();
    test_back_pressure();
    test_credit_return();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/serial_link.sv
//////////////////////////////
// Serial link top level with network, data link and physical layers
// Set the parameters here, they are passed down to each layer
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_link import serial_link_pkg::*; #(
  parameter int DataWidth  = DefaultDataWidth,
  parameter int NumLanes   = DefaultNumLanes,
  parameter int NumCredits = DefaultNumCredits,
  parameter int ClkDiv     = DefaultClkDiv
) (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // User transmit stream
  input  wire  [DataWidth-1:0] tx_data_i,
  input  wire                  tx_valid_i,
  output logic                 tx_ready_o,
  // User receive stream
  output logic [DataWidth-1:0] rx_data_o,
  output logic                 rx_valid_o,
  input  wire                  rx_ready_i,
  // Link lines
  input  wire  [NumLanes-1:0]  ddr_i,
  output logic [NumLanes-1:0]  ddr_o,
  input  wire                  ddr_rcv_clk_i,
  output logic                 ddr_rcv_clk_o
);

  // Word, tag bit and credit field
  localparam int CreditWidth  = $clog2(NumCredits) + 1;
  localparam int PayloadWidth = DataWidth + 1 + CreditWidth;

  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [NumLanes-1:0]     flit_t;

  payload_t tx_payload;
  payload_t rx_payload;
  logic     tx_payload_valid;
  logic     tx_payload_ready;
  logic     rx_payload_valid;

  flit_t    tx_flit;
  flit_t    rx_flit;
  logic     tx_flit_valid;
  logic     tx_flit_ready;
  logic     rx_flit_valid;

  //////////////////////////////
  // Network layer
  //////////////////////////////

  serial_link_network #(
    .DataWidth  ( DataWidth  ),
    .NumCredits ( NumCredits )
  ) i_network (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .tx_data_i          ( tx_data_i        ),
    .tx_valid_i         ( tx_valid_i       ),
    .tx_ready_o         ( tx_ready_o       ),
    .rx_data_o          ( rx_data_o        ),
    .rx_valid_o         ( rx_valid_o       ),
    .rx_ready_i         ( rx_ready_i       ),
    .tx_payload_o       ( tx_payload       ),
    .tx_payload_valid_o ( tx_payload_valid ),
    .tx_payload_ready_i ( tx_payload_ready ),
    .rx_payload_i       ( rx_payload       ),
    .rx_payload_valid_i ( rx_payload_valid )
  );

  //////////////////////////////
  // Data link layer
  //////////////////////////////

  serial_link_data_link #(
    .NumLanes     ( NumLanes     ),
    .PayloadWidth ( PayloadWidth )
  ) i_data_link (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .tx_payload_i       ( tx_payload       ),
    .tx_payload_valid_i ( tx_payload_valid ),
    .tx_payload_ready_o ( tx_payload_ready ),
    .rx_payload_o       ( rx_payload       ),
    .rx_payload_valid_o ( rx_payload_valid ),
    .tx_flit_o          ( tx_flit          ),
    .tx_flit_valid_o    ( tx_flit_valid    ),
    .tx_flit_ready_i    ( tx_flit_ready    ),
    .rx_flit_i          ( rx_flit          ),
    .rx_flit_valid_i    ( rx_flit_valid    )
  );

  //////////////////////////////
  // Physical layer
  //////////////////////////////

  serial_link_physical #(
    .NumLanes ( NumLanes ),
    .ClkDiv   ( ClkDiv   )
  ) i_physical (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .tx_flit_i       ( tx_flit       ),
    .tx_flit_valid_i ( tx_flit_valid ),
    .tx_flit_ready_o ( tx_flit_ready ),
    .rx_flit_o       ( rx_flit       ),
    .rx_flit_valid_o ( rx_flit_valid ),
    .ddr_i           ( ddr_i         ),
    .ddr_o           ( ddr_o         ),
    .ddr_rcv_clk_i   ( ddr_rcv_clk_i ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk_o )
  );

endmodule

`default_nettype wire

// File: physical/serial_link_physical.sv
//////////////////////////////
// Physical layer with a forwarded clock, one clock period per flit
// The receiver synchronizes clock and lanes to clk_i
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_link_physical import serial_link_pkg::*; #(
  parameter int NumLanes = DefaultNumLanes,
  parameter int ClkDiv   = DefaultClkDiv
) (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire  [NumLanes-1:0] tx_flit_i,
  input  wire                 tx_flit_valid_i,
  output logic                tx_flit_ready_o,
  output logic [NumLanes-1:0] rx_flit_o,
  output logic                rx_flit_valid_o,
  input  wire  [NumLanes-1:0] ddr_i,
  output logic [NumLanes-1:0] ddr_o,
  input  wire                 ddr_rcv_clk_i,
  output logic                ddr_rcv_clk_o
);

  localparam int HalfDiv  = ClkDiv / 2;
  localparam int CntWidth = $clog2(HalfDiv);

  typedef logic [NumLanes-1:0] flit_t;
  typedef logic [CntWidth-1:0] div_cnt_t;

  phy_state_e state_q;
  div_cnt_t   div_cnt_q;

  logic  clk_meta_q;
  logic  clk_sync_q;
  logic  clk_prev_q;
  flit_t data_meta_q;
  flit_t data_sync_q;
  logic  rx_edge;

  //////////////////////////////
  // Transmit
  //////////////////////////////

  // The idle cycle counts toward the period, so a flit takes ClkDiv cycles
  assign tx_flit_ready_o = (state_q == PHY_IDLE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= PHY_IDLE;
      div_cnt_q     <= '0;
      ddr_o         <= '0;
      ddr_rcv_clk_o <= 1'b0;
    end else begin
      case (state_q)
        PHY_IDLE: begin
          if (tx_flit_valid_i) begin
            ddr_o     <= tx_flit_i;
            div_cnt_q <= '0;
            state_q   <= PHY_LOW;
          end
        end
        // Data settles for a half period before the rising edge
        PHY_LOW: begin
          if (div_cnt_q == div_cnt_t'(HalfDiv - 1)) begin
            ddr_rcv_clk_o <= 1'b1;
            div_cnt_q     <= '0;
            state_q       <= PHY_HIGH;
          end else begin
            div_cnt_q <= div_cnt_q + div_cnt_t'(1);
          end
        end
        PHY_HIGH: begin
          if (div_cnt_q == div_cnt_t'(HalfDiv - 2)) begin
            ddr_rcv_clk_o <= 1'b0;
            state_q       <= PHY_IDLE;
          end else begin
            div_cnt_q <= div_cnt_q + div_cnt_t'(1);
          end
        end
        default: state_q <= PHY_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Receive
  //////////////////////////////

  assign rx_edge = clk_sync_q && !clk_prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_meta_q      <= 1'b0;
      clk_sync_q      <= 1'b0;
      clk_prev_q      <= 1'b0;
      rx_flit_valid_o <= 1'b0;
    end else begin
      clk_meta_q      <= ddr_rcv_clk_i;
      clk_sync_q      <= clk_meta_q;
      clk_prev_q      <= clk_sync_q;
      rx_flit_valid_o <= rx_edge;
    end
  end

  // Lanes take the same two stages as the clock
  always_ff @(posedge clk_i) begin
    data_meta_q <= ddr_i;
    data_sync_q <= data_meta_q;
    if (rx_edge) begin
      rx_flit_o <= data_sync_q;
    end
  end

endmodule

`default_nettype wire

// File: data_link/serial_link_data_link.sv
//////////////////////////////
// Data link layer, payloads to lane-wide flits and back
// Flits go out lowest lanes first, the last one zero padded
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_link_data_link import serial_link_pkg::*; #(
  parameter int NumLanes     = DefaultNumLanes,
  parameter int PayloadWidth = DefaultDataWidth + $clog2(DefaultNumCredits) + 2
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire  [PayloadWidth-1:0] tx_payload_i,
  input  wire                     tx_payload_valid_i,
  output logic                    tx_payload_ready_o,
  output logic [PayloadWidth-1:0] rx_payload_o,
  output logic                    rx_payload_valid_o,
  output logic [NumLanes-1:0]     tx_flit_o,
  output logic                    tx_flit_valid_o,
  input  wire                     tx_flit_ready_i,
  input  wire  [NumLanes-1:0]     rx_flit_i,
  input  wire                     rx_flit_valid_i
);

  localparam int NumFlits    = (PayloadWidth + NumLanes - 1) / NumLanes;
  localparam int PaddedWidth = NumFlits * NumLanes;
  localparam int CntWidth    = (NumFlits > 1) ? $clog2(NumFlits) : 1;

  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [NumLanes-1:0]     flit_t;
  typedef logic [PaddedWidth-1:0]  padded_t;
  typedef logic [CntWidth-1:0]     cnt_t;

  link_state_e state_q;
  padded_t     tx_shift_q;
  padded_t     rx_shift_q;
  cnt_t        tx_cnt_q;
  cnt_t        rx_cnt_q;
  logic        tx_last;
  logic        rx_last;

  //////////////////////////////
  // Transmit
  //////////////////////////////

  assign tx_payload_ready_o = (state_q == LINK_IDLE);
  assign tx_flit_valid_o    = (state_q == LINK_SEND);
  assign tx_flit_o          = flit_t'(tx_shift_q[NumLanes-1:0]);
  assign tx_last            = (tx_cnt_q == cnt_t'(NumFlits - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= LINK_IDLE;
      tx_cnt_q <= '0;
    end else begin
      case (state_q)
        LINK_IDLE: begin
          if (tx_payload_valid_i) begin
            state_q  <= LINK_SEND;
            tx_cnt_q <= '0;
          end
        end
        LINK_SEND: begin
          if (tx_flit_ready_i) begin
            tx_cnt_q <= tx_cnt_q + cnt_t'(1);
            if (tx_last) begin
              state_q <= LINK_IDLE;
            end
          end
        end
        default: state_q <= LINK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_payload_valid_i && tx_payload_ready_o) begin
      tx_shift_q <= padded_t'(tx_payload_i);
    end else if (tx_flit_valid_o && tx_flit_ready_i) begin
      tx_shift_q <= tx_shift_q >> NumLanes;
    end
  end

  //////////////////////////////
  // Receive
  //////////////////////////////

  // New flits enter at the top, so the first one ends up at the bottom
  assign rx_last      = (rx_cnt_q == cnt_t'(NumFlits - 1));
  assign rx_payload_o = payload_t'(rx_shift_q[PayloadWidth-1:0]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_cnt_q           <= '0;
      rx_payload_valid_o <= 1'b0;
    end else begin
      rx_payload_valid_o <= rx_flit_valid_i && rx_last;
      if (rx_flit_valid_i) begin
        rx_cnt_q <= rx_last ? '0 : rx_cnt_q + cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_flit_valid_i) begin
      rx_shift_q <= (rx_shift_q >> NumLanes)
                  | (padded_t'(rx_flit_i) << (PaddedWidth - NumLanes));
    end
  end

endmodule

`default_nettype wire

// File: network/serial_link_network.sv
//////////////////////////////
// Network layer with credit based flow control
// Packs user words and returned credits into payloads and unpacks them
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_link_network import serial_link_pkg::*; #(
  parameter int DataWidth    = DefaultDataWidth,
  parameter int NumCredits   = DefaultNumCredits,
  localparam int CreditWidth  = $clog2(NumCredits) + 1,
  localparam int PayloadWidth = DataWidth + 1 + CreditWidth
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire  [DataWidth-1:0]    tx_data_i,
  input  wire                     tx_valid_i,
  output logic                    tx_ready_o,
  output logic [DataWidth-1:0]    rx_data_o,
  output logic                    rx_valid_o,
  input  wire                     rx_ready_i,
  output logic [PayloadWidth-1:0] tx_payload_o,
  output logic                    tx_payload_valid_o,
  input  wire                     tx_payload_ready_i,
  input  wire  [PayloadWidth-1:0] rx_payload_i,
  input  wire                     rx_payload_valid_i
);

  typedef logic [DataWidth-1:0]   word_t;
  typedef logic [CreditWidth-1:0] credit_t;

  word_t   word_q;
  logic    word_valid_q;
  logic    word_take;
  credit_t credit_q;
  credit_t credit_d;
  credit_t pending_q;
  credit_t pending_d;
  tag_e    tx_tag;
  logic    tx_fire;
  logic    data_sent;

  word_t   rx_word;
  tag_e    rx_tag;
  credit_t rx_credit;
  logic    push;
  logic    pop;

  //////////////////////////////
  // Transmit side
  //////////////////////////////

  assign tx_ready_o = !word_valid_q && (credit_q != '0);
  assign word_take  = tx_valid_i && tx_ready_o;

  // A waiting word wins, otherwise a credit-only payload
  assign tx_tag             = word_valid_q ? TAG_DATA : TAG_CREDIT;
  assign tx_payload_valid_o = word_valid_q || (pending_q != '0);
  assign tx_payload_o       = {word_q, tx_tag, pending_q};
  assign tx_fire            = tx_payload_valid_o && tx_payload_ready_i;
  assign data_sent          = tx_fire && (tx_tag == TAG_DATA);

  //////////////////////////////
  // Receive side
  //////////////////////////////

  assign rx_word   = rx_payload_i[PayloadWidth-1 -: DataWidth];
  assign rx_tag    = tag_e'(rx_payload_i[CreditWidth]);
  assign rx_credit = rx_payload_i[CreditWidth-1:0];
  assign push      = rx_payload_valid_i && (rx_tag == TAG_DATA);
  assign pop       = rx_valid_o && rx_ready_i;

  always_comb begin
    credit_d = credit_q;
    if (data_sent) begin
      credit_d = credit_d - credit_t'(1);
    end
    if (rx_payload_valid_i) begin
      credit_d = credit_d + rx_credit;
    end
  end

  // Every outgoing payload hands back all pending credits
  assign pending_d = (tx_fire ? '0 : pending_q) + credit_t'(pop);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_valid_q <= 1'b0;
      credit_q     <= credit_t'(NumCredits);
      pending_q    <= '0;
    end else begin
      credit_q  <= credit_d;
      pending_q <= pending_d;
      if (word_take) begin
        word_valid_q <= 1'b1;
      end else if (data_sent) begin
        word_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_take) begin
      word_q <= tx_data_i;
    end
  end

  serial_link_recv_fifo #(
    .DataWidth  ( DataWidth  ),
    .NumCredits ( NumCredits )
  ) i_recv_fifo (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( push       ),
    .push_data_i ( rx_word    ),
    .pop_data_o  ( rx_data_o  ),
    .pop_valid_o ( rx_valid_o ),
    .pop_ready_i ( rx_ready_i )
  );

endmodule

`default_nettype wire

// File: network/serial_link_recv_fifo.sv
//////////////////////////////
// Receive FIFO for data words, one slot per credit
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_link_recv_fifo import serial_link_pkg::*; #(
  parameter int DataWidth  = DefaultDataWidth,
  parameter int NumCredits = DefaultNumCredits
) (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire                  push_i,
  input  wire  [DataWidth-1:0] push_data_i,
  output logic [DataWidth-1:0] pop_data_o,
  output logic                 pop_valid_o,
  input  wire                  pop_ready_i
);

  localparam int PtrWidth = (NumCredits > 1) ? $clog2(NumCredits) : 1;
  localparam int CntWidth = $clog2(NumCredits + 1);

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [PtrWidth-1:0]  ptr_t;
  typedef logic [CntWidth-1:0]  cnt_t;

  word_t mem_q [NumCredits];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;
  logic  pop;

  // Pointers wrap at the depth, which need not be a power of two
  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(NumCredits - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];
  assign pop         = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: common/serial_link_pkg.sv
//////////////////////////////
// Shared types and default parameter values for the serial link
// Modules take them in with a wildcard import in their header
//////////////////////////////

`default_nettype none

package serial_link_pkg;

  //////////////////////////////
  // Payload and FSM encodings
  //////////////////////////////

  // Kind of payload on the link
  typedef enum logic {
    TAG_DATA   = 1'b0,
    TAG_CREDIT = 1'b1
  } tag_e;

  // Data link transmit FSM
  typedef enum logic {
    LINK_IDLE = 1'b0,
    LINK_SEND = 1'b1
  } link_state_e;

  // Physical transmit FSM, one state per half of the forwarded clock
  typedef enum logic [1:0] {
    PHY_IDLE = 2'd0,
    PHY_LOW  = 2'd1,
    PHY_HIGH = 2'd2
  } phy_state_e;

  //////////////////////////////
  // Default parameters
  //////////////////////////////

  // User word width
  localparam int DefaultDataWidth = 16;
  // Lanes of the physical link
  localparam int DefaultNumLanes = 8;
  // Receive FIFO depth, also the initial credit count
  localparam int DefaultNumCredits = 8;
  // clk_i cycles per forwarded clock period, even and at least 6
  localparam int DefaultClkDiv = 8;

endpackage

`default_nettype wire
